/* flist.f */
source/feat_pkg.sv
source/img_store.sv
source/row_window.sv
source/gauss_blur.sv
source/keypoint_detect.sv
source/keypoint_store.sv
source/phase_ctrl.sv
source/feat_core.sv
verif/feat_core_sva.sv
verif/feat_core_checker.sv
verif/feat_core_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module feat_core_tb -f flist.f \
    -o feat_core_sim && ./obj_dir/feat_core_sim 2>&1 | tee sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verif/feat_core_tb.sv */
`timescale 1ns/1ps
module feat_core_tb;
    import feat_pkg::*;

    localparam int n_runs = 6;
    localparam int max_cycles = 16 + n_runs * (320 + 200);

    // pattern 0 zero, 1 spot, 2 new random, 3 keep last image
    localparam int t_pat [n_runs] = '{0, 1, 2, 3, 3, 2};
    localparam int t_val [n_runs] = '{0, 160, 0, 0, 0, 0};
    localparam int t_pos [n_runs] = '{0, 87, 0, 0, 0, 0};       // row 5 col 7
    localparam int t_flt [n_runs] = '{0, 0, 0, 1, 1, 1};
    localparam int t_thr [n_runs] = '{-1, 50, -3, -3, -3, 0};
    localparam int t_exp [n_runs] = '{256, 1, -1, -1, -1, -1};  // -1 means model count
    localparam int t_rule [n_runs] = '{0, 0, 0, 1, 2, 0};       // 1 not above last, 2 same
    localparam int t_bwr [n_runs] = '{0, 0, 0, 0, 1, 1};        // host writes while busy

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic                    filter_on;
    logic signed [dog_w-1:0] filter_threshold;
    logic                    img_we;
    logic [row_aw-1:0]       img_addr;
    logic [row_w-1:0]        img_din;
    logic [kpt_aw-1:0]       kpt_addr;
    logic                    busy;
    logic                    done;
    logic [kpt_w-1:0]        kpt_dout;
    logic [kpt_cw-1:0]       kpt_count;
    int                      exp_count;
    int                      cnt_rule;
    int                      check_errors;
    int                      checked_runs;
    int                      cycles = 0;

    feat_core feat_core_i (.*);

    feat_core_checker checker_i (.*, .errors(check_errors), .checked(checked_runs));

    bind feat_core feat_core_sva feat_core_sva_i (
        .clk(clk), .rst_n(rst_n), .busy(busy), .done(done), .clear(clear),
        .kpt_we(kpt_we), .kpt_count(kpt_count), .phase(phase_ctrl_i.phase)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the runs did not finish within %0d cycles", max_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic load_image(input int pat, input int val, input int pos);
        logic [row_w-1:0] row;
        for (int r = 0; r < img_h; r++) begin
            row = '0;
            for (int c = 0; c < img_w; c++) begin
                if (pat == 2) begin
                    row[c*pix_w +: pix_w] = pix_w'($urandom);
                end else if (pat == 1 && r * img_w + c == pos) begin
                    row[c*pix_w +: pix_w] = pix_w'(val);
                end
            end
            img_we <= 1'b1;
            img_addr <= row_aw'(r);
            img_din <= row;
            @(posedge clk);
        end
        img_we <= 1'b0;
    endtask

    initial begin
        int n_wr;
        int seen;
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        filter_on = 1'b0;
        filter_threshold = '0;
        img_we = 1'b0;
        img_addr = '0;
        img_din = '0;
        exp_count = -1;
        cnt_rule = 0;
        void'($urandom(83878));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < n_runs; i++) begin
            if (t_pat[i] != 3) begin
                load_image(t_pat[i], t_val[i], t_pos[i]);
            end
            filter_on <= t_flt[i] != 0;
            filter_threshold <= dog_w'(t_thr[i]);
            exp_count <= t_exp[i];
            cnt_rule <= t_rule[i];
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            seen = checked_runs;
            n_wr = 0;
            while (!done) begin
                @(posedge clk);
                if (t_bwr[i] != 0 && busy && n_wr < 32) begin   // image store must drop these
                    img_we <= 1'b1;
                    img_addr <= row_aw'($urandom);
                    img_din <= {$urandom, $urandom, $urandom, $urandom};
                    n_wr++;
                end else begin
                    img_we <= 1'b0;
                end
            end
            while (checked_runs == seen) begin
                @(posedge clk);
            end
        end
        $display("checked %0d of %0d runs, %0d errors", checked_runs, n_runs, check_errors);
        if (check_errors == 0 && checked_runs == n_runs) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verif/feat_core_checker.sv */
`timescale 1ns/1ps
module feat_core_checker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic                              busy,
    input  logic                              done,
    input  logic                              filter_on,
    input  logic signed [feat_pkg::dog_w-1:0] filter_threshold,
    input  logic                              img_we,
    input  logic [feat_pkg::row_aw-1:0]       img_addr,
    input  logic [feat_pkg::row_w-1:0]        img_din,
    input  logic [feat_pkg::kpt_w-1:0]        kpt_dout,
    input  logic [feat_pkg::kpt_cw-1:0]       kpt_count,
    input  int                                exp_count,
    input  int                                cnt_rule,
    output logic [feat_pkg::kpt_aw-1:0]       kpt_addr,
    output int                                errors,
    output int                                checked
);
    import feat_pkg::*;

    logic [row_w-1:0] img [img_h];      // rows the DUT accepted
    logic [kpt_w-1:0] exp_q [$];
    logic             run_filter;
    int               run_thr;
    int               prev_count;

    always @(posedge clk) begin
        if (rst_n && img_we && !busy) begin
            img[img_addr] <= img_din;
        end
        if (rst_n && start && !busy) begin
            run_filter <= filter_on;
            run_thr <= int'(filter_threshold);
        end
    end

    function automatic int pixel(input int r, input int c);
        if (r < 0 || r >= img_h || c < 0 || c >= img_w) begin
            return 0;       // zero padding
        end
        return int'(img[r][c*pix_w +: pix_w]);
    endfunction

    function automatic int blurred(input int r, input int c);
        int s;
        s = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                s += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * pixel(r + dr, c + dc);
            end
        end
        return (s + gauss_round) >> 4;
    endfunction

    task automatic build_expected();
        int   dog [img_w];
        logic keep;
        exp_q.delete();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                dog[c] = pixel(r, c) - blurred(r, c);
            end
            for (int c = 0; c < img_w; c++) begin
                keep = dog[c] > run_thr;
                if (run_filter) begin
                    keep = keep && (c == 0 || dog[c] > dog[c-1]);
                    keep = keep && (c == img_w - 1 || dog[c] > dog[c+1]);
                end
                if (keep) begin
                    exp_q.push_back({row_aw'(r), col_w'(c), dog_w'(dog[c])});
                end
            end
        end
    endtask

    task automatic verify_run();
        int n;
        build_expected();
        n = int'(kpt_count);
        if (n != exp_q.size() || (exp_count >= 0 && n != exp_count)) begin
            $display("Error %0t: kpt_count %0d, model gives %0d, table gives %0d",
                $time, n, exp_q.size(), exp_count);
            errors++;
        end
        if ((cnt_rule == 1 && n > prev_count) || (cnt_rule == 2 && n != prev_count)) begin
            $display("Error %0t: kpt_count %0d against %0d in the run before",
                $time, n, prev_count);
            errors++;
        end
        // record k-2 sits on kpt_dout while address k goes out
        for (int k = 0; k < n + 2; k++) begin
            if (k >= 2 && k - 2 < exp_q.size() && kpt_dout !== exp_q[k-2]) begin
                $display("Error %0t: record %0d is row %0d col %0d dog %0d, expected %0d %0d %0d",
                    $time, k - 2, kpt_dout[17:14], kpt_dout[13:10], $signed(kpt_dout[9:0]),
                    exp_q[k-2][17:14], exp_q[k-2][13:10], $signed(exp_q[k-2][9:0]));
                errors++;
            end
            if (k < n) begin
                kpt_addr <= kpt_aw'(k);
            end
            @(posedge clk);
        end
        prev_count = n;
    endtask

    initial begin
        int run_cyc;
        errors = 0;
        checked = 0;
        prev_count = 0;
        run_cyc = 0;
        kpt_addr = '0;
        wait (rst_n);
        @(posedge clk);
        if (kpt_count !== '0) begin
            $display("Error %0t: kpt_count %0d after reset", $time, kpt_count);
            errors++;
        end
        forever begin
            @(posedge clk);
            run_cyc = busy ? run_cyc + 1 : 0;
            if (run_cyc == 2 && kpt_count !== '0) begin    // window clear has passed
                $display("Error %0t: kpt_count %0d not cleared by start", $time, kpt_count);
                errors++;
            end
            if (done) begin
                verify_run();
                checked++;
            end
        end
    end

endmodule

/* verif/feat_core_sva.sv */
`timescale 1ns/1ps
module feat_core_sva (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        busy,
    input logic                        done,
    input logic                        clear,
    input logic                        kpt_we,
    input logic [feat_pkg::kpt_cw-1:0] kpt_count,
    input logic [1:0]                  phase
);
    import feat_pkg::*;

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done high for more than one cycle");

    done_at_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        done == $fell(busy))
        else $error("done and the fall of busy are not in the same cycle");

    // records only come out of the detect phase
    we_in_detect: assert property (@(posedge clk) disable iff (!rst_n)
        kpt_we |-> busy && phase == ph_detect)
        else $error("keypoint write outside the detect phase");

    count_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
        busy && $past(busy) && !$past(clear) |-> kpt_count >= $past(kpt_count))
        else $error("kpt_count decreased during a run");

endmodule

/* source/feat_core.sv */
`timescale 1ns/1ps
module feat_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic                                filter_on,
    input  logic signed [feat_pkg::dog_w-1:0]   filter_threshold,
    input  logic                                img_we,
    input  logic [feat_pkg::row_aw-1:0]         img_addr,
    input  logic [feat_pkg::row_w-1:0]          img_din,
    input  logic [feat_pkg::kpt_aw-1:0]         kpt_addr,
    output logic                                busy,
    output logic                                done,
    output logic [feat_pkg::kpt_w-1:0]          kpt_dout,
    output logic [feat_pkg::kpt_cw-1:0]         kpt_count
);
    import feat_pkg::*;

    logic [row_aw-1:0] rd_addr;
    logic [row_w-1:0]  row_data;
    logic              clear;
    logic              shift;
    logic              fill_zero;
    logic [row_w-1:0]  row_prev;
    logic [row_w-1:0]  row_cur;
    logic [row_w-1:0]  row_next;
    logic              blur_we;
    logic [row_aw-1:0] blur_waddr;
    logic [row_aw-1:0] blur_raddr;
    logic [row_w-1:0]  blur_rdata;
    logic [row_aw-1:0] det_raddr;
    logic              go;
    logic              finished;
    logic              kpt_we;
    logic [kpt_w-1:0]  kpt_wdata;

    img_store img_store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .img_we   (img_we),
        .img_addr (img_addr),
        .img_din  (img_din),
        .busy     (busy),
        .rd_addr  (rd_addr),
        .row_data (row_data)
    );

    phase_ctrl phase_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .finished   (finished),
        .det_raddr  (det_raddr),
        .rd_addr    (rd_addr),
        .clear      (clear),
        .shift      (shift),
        .fill_zero  (fill_zero),
        .blur_we    (blur_we),
        .blur_waddr (blur_waddr),
        .go         (go),
        .busy       (busy),
        .done       (done)
    );

    row_window row_window_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .shift     (shift),
        .fill_zero (fill_zero),
        .row_in    (row_data),
        .row_prev  (row_prev),
        .row_cur   (row_cur),
        .row_next  (row_next)
    );

    gauss_blur gauss_blur_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_prev   (row_prev),
        .row_cur    (row_cur),
        .row_next   (row_next),
        .blur_we    (blur_we),
        .blur_waddr (blur_waddr),
        .blur_raddr (blur_raddr),
        .blur_rdata (blur_rdata)
    );

    keypoint_detect keypoint_detect_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .go               (go),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .img_raddr        (det_raddr),
        .img_rdata        (row_data),
        .blur_raddr       (blur_raddr),
        .blur_rdata       (blur_rdata),
        .kpt_we           (kpt_we),
        .kpt_wdata        (kpt_wdata),
        .finished         (finished)
    );

    // count restarts with the window clear
    keypoint_store keypoint_store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_clr (clear),
        .kpt_we    (kpt_we),
        .kpt_wdata (kpt_wdata),
        .kpt_addr  (kpt_addr),
        .kpt_dout  (kpt_dout),
        .kpt_count (kpt_count)
    );

endmodule

/* source/phase_ctrl.sv */
`timescale 1ns/1ps
module phase_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         finished,
    input  logic [feat_pkg::row_aw-1:0]  det_raddr,
    output logic [feat_pkg::row_aw-1:0]  rd_addr,
    output logic                         clear,
    output logic                         shift,
    output logic                         fill_zero,
    output logic                         blur_we,
    output logic [feat_pkg::row_aw-1:0]  blur_waddr,
    output logic                         go,
    output logic                         busy,
    output logic                         done
);
    import feat_pkg::*;

    logic [1:0]      phase;
    logic [row_aw:0] bcnt;      // blur step 0..18
    logic            in_blur;
    logic            blur_end;

    assign in_blur = phase == ph_blur;
    assign blur_end = in_blur && (bcnt == (row_aw + 1)'(img_h + 2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= ph_idle;
            bcnt <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (start) begin
                        phase <= ph_blur;
                        bcnt <= '0;
                    end
                end
                ph_blur: begin
                    if (blur_end) begin
                        phase <= ph_detect;
                    end else begin
                        bcnt <= bcnt + 1'b1;
                    end
                end
                ph_detect: begin
                    if (finished) begin
                        phase <= ph_idle;
                        done <= 1'b1;       // lands with busy falling
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    assign busy = phase != ph_idle;

    // rows 0..15 requested on steps 0..15, detect owns the port afterwards
    assign rd_addr = (phase == ph_detect) ? det_raddr : bcnt[row_aw-1:0];

    assign clear = in_blur && (bcnt == '0);
    assign shift = in_blur && (bcnt != '0) && (bcnt <= (row_aw + 1)'(img_h + 1));
    assign fill_zero = in_blur && (bcnt == (row_aw + 1)'(img_h + 1));   // bottom pad

    // centre row k-1 is ready once row k sits in the window
    assign blur_we = in_blur && (bcnt >= (row_aw + 1)'(3));
    assign blur_waddr = bcnt[row_aw-1:0] - row_aw'(3);

    assign go = blur_end;

endmodule

/* source/keypoint_store.sv */
`timescale 1ns/1ps
module keypoint_store (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_clr,
    input  logic                         kpt_we,
    input  logic [feat_pkg::kpt_w-1:0]   kpt_wdata,
    input  logic [feat_pkg::kpt_aw-1:0]  kpt_addr,
    output logic [feat_pkg::kpt_w-1:0]   kpt_dout,
    output logic [feat_pkg::kpt_cw-1:0]  kpt_count
);
    import feat_pkg::*;

    logic [kpt_w-1:0] kpt_mem [2**kpt_aw];

    // count doubles as the write pointer
    always_ff @(posedge clk) begin
        if (!rst_n || start_clr) begin
            kpt_count <= '0;
        end else if (kpt_we) begin
            kpt_count <= kpt_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && kpt_we) begin
            kpt_mem[kpt_count[kpt_aw-1:0]] <= kpt_wdata;
        end
        kpt_dout <= kpt_mem[kpt_addr];      // host read, one cycle
    end

endmodule

/* source/keypoint_detect.sv */
`timescale 1ns/1ps
module keypoint_detect (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                go,
    input  logic                                filter_on,
    input  logic signed [feat_pkg::dog_w-1:0]   filter_threshold,
    output logic [feat_pkg::row_aw-1:0]         img_raddr,
    input  logic [feat_pkg::row_w-1:0]          img_rdata,
    output logic [feat_pkg::row_aw-1:0]         blur_raddr,
    input  logic [feat_pkg::row_w-1:0]          blur_rdata,
    output logic                                kpt_we,
    output logic [feat_pkg::kpt_w-1:0]          kpt_wdata,
    output logic                                finished
);
    import feat_pkg::*;

    logic                    active;
    logic [row_aw-1:0]       row;
    logic [col_w:0]          step;      // 0 address, 1 capture, 2..17 scan
    logic [col_w-1:0]        col;
    logic signed [dog_w-1:0] dog [img_w];
    logic                    last_step;
    logic                    scan;
    logic                    thr_ok;
    logic                    left_ok;
    logic                    right_ok;

    assign col = step[col_w-1:0] - col_w'(2);
    assign last_step = step == (col_w + 1)'(img_w + 1);
    assign scan = active && (step >= (col_w + 1)'(2));

    // same row address to both memories
    assign img_raddr = row;
    assign blur_raddr = row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            row <= '0;
            step <= '0;
        end else if (!active) begin
            if (go) begin
                active <= 1'b1;
                row <= '0;
                step <= '0;
            end
        end else if (last_step) begin
            step <= '0;
            row <= row + 1'b1;
            if (row == row_aw'(img_h - 1)) begin
                active <= 1'b0;
            end
        end else begin
            step <= step + 1'b1;
        end
    end

    // both rows valid one cycle after the address
    always_ff @(posedge clk) begin
        if (active && step == (col_w + 1)'(1)) begin
            for (int c = 0; c < img_w; c++) begin
                dog[c] <= $signed({2'b00, img_rdata[c*pix_w +: pix_w]})
                        - $signed({2'b00, blur_rdata[c*pix_w +: pix_w]});
            end
        end
    end

    assign thr_ok = dog[col] > filter_threshold;
    assign left_ok = (col == '0) || (dog[col] > dog[col - 1'b1]);    // edge passes
    assign right_ok = (col == '1) || (dog[col] > dog[col + 1'b1]);

    assign kpt_we = scan && thr_ok && (!filter_on || (left_ok && right_ok));
    assign kpt_wdata = {row, col, dog[col]};

    assign finished = active && last_step && (row == row_aw'(img_h - 1));

endmodule

/* source/gauss_blur.sv */
`timescale 1ns/1ps
module gauss_blur (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [feat_pkg::row_w-1:0]   row_prev,
    input  logic [feat_pkg::row_w-1:0]   row_cur,
    input  logic [feat_pkg::row_w-1:0]   row_next,
    input  logic                         blur_we,
    input  logic [feat_pkg::row_aw-1:0]  blur_waddr,
    input  logic [feat_pkg::row_aw-1:0]  blur_raddr,
    output logic [feat_pkg::row_w-1:0]   blur_rdata
);
    import feat_pkg::*;

    logic [row_w-1:0] blur_mem [img_h];
    logic [row_w-1:0] blur_row;

    // pixel c of a row, zero outside the image
    function automatic logic [pix_w-1:0] px(input logic [row_w-1:0] row, input int c);
        logic [pix_w-1:0] p;
        p = '0;
        if (c >= 0 && c < img_w) begin
            p = row[c*pix_w +: pix_w];
        end
        return p;
    endfunction

    // horizontal 1 2 1 pass
    function automatic logic [pix_w+1:0] hsum(input logic [row_w-1:0] row, input int c);
        logic [pix_w+1:0] l;
        logic [pix_w+1:0] m;
        logic [pix_w+1:0] r;
        l = {2'b00, px(row, c - 1)};
        m = {1'b0, px(row, c), 1'b0};
        r = {2'b00, px(row, c + 1)};
        return l + m + r;
    endfunction

    always_comb begin
        logic [pix_w+3:0] sum;      // max 16 * 255 plus rounding
        blur_row = '0;
        for (int c = 0; c < img_w; c++) begin
            sum = {2'b00, hsum(row_prev, c)}
                + {1'b0, hsum(row_cur, c), 1'b0}
                + {2'b00, hsum(row_next, c)}
                + (pix_w + 4)'(gauss_round);
            blur_row[c*pix_w +: pix_w] = sum[pix_w+3:4];   // divide by 16
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && blur_we) begin
            blur_mem[blur_waddr] <= blur_row;
        end
        blur_rdata <= blur_mem[blur_raddr];
    end

endmodule

/* source/row_window.sv */
`timescale 1ns/1ps
module row_window (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  logic                        shift,
    input  logic                        fill_zero,
    input  logic [feat_pkg::row_w-1:0]  row_in,
    output logic [feat_pkg::row_w-1:0]  row_prev,
    output logic [feat_pkg::row_w-1:0]  row_cur,
    output logic [feat_pkg::row_w-1:0]  row_next
);
    import feat_pkg::*;

    logic [row_w-1:0] row_load;

    // zero rows pad the image top and bottom
    assign row_load = fill_zero ? '0 : row_in;

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            row_prev <= '0;
            row_cur <= '0;
            row_next <= '0;
        end else if (shift) begin
            row_prev <= row_cur;
            row_cur <= row_next;
            row_next <= row_load;
        end
    end

endmodule

/* source/img_store.sv */
`timescale 1ns/1ps
module img_store (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         img_we,
    input  logic [feat_pkg::row_aw-1:0]  img_addr,
    input  logic [feat_pkg::row_w-1:0]   img_din,
    input  logic                         busy,
    input  logic [feat_pkg::row_aw-1:0]  rd_addr,
    output logic [feat_pkg::row_w-1:0]   row_data
);
    import feat_pkg::*;

    logic [row_w-1:0] img_mem [img_h];
    logic             wr_ok;

    // host loads only while the engine is idle
    assign wr_ok = rst_n && img_we && !busy;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            img_mem[img_addr] <= img_din;
        end
    end

    always_ff @(posedge clk) begin
        row_data <= img_mem[rd_addr];   // one cycle latency
    end

endmodule

/* source/feat_pkg.sv */
package feat_pkg;

    // image geometry
    localparam int img_w = 16;
    localparam int img_h = 16;
    localparam int pix_w = 8;
    localparam int row_w = img_w * pix_w;       // one full row per word
    localparam int row_aw = 4;
    localparam int col_w = 4;

    // signed image minus blur
    localparam int dog_w = 10;

    // record is {row, col, dog}
    localparam int kpt_w = row_aw + col_w + dog_w;
    localparam int kpt_aw = 8;                  // one slot per pixel
    localparam int kpt_cw = 9;

    localparam int gauss_round = 8;             // added before the >> 4

    // sequencer phases
    localparam logic [1:0] ph_idle = 2'd0;
    localparam logic [1:0] ph_blur = 2'd1;
    localparam logic [1:0] ph_detect = 2'd2;

endpackage
